// ==== icache_consts.svh ====
// geometry of the instruction cache
// derived widths assume 32-bit instructions and power-of-two sizes
// replacement logic assumes exactly two ways
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// base geometry
`define ICACHE_ADDR_W     32
`define ICACHE_SETS       16
`define ICACHE_WAYS       2
`define ICACHE_LINE_WORDS 4

// derived field widths
`define ICACHE_IDX_W  ($clog2(`ICACHE_SETS))
`define ICACHE_WORD_W ($clog2(`ICACHE_LINE_WORDS))
`define ICACHE_BYTE_W 2
`define ICACHE_WAY_W  ($clog2(`ICACHE_WAYS))
`define ICACHE_TAG_W  (`ICACHE_ADDR_W - `ICACHE_IDX_W - `ICACHE_WORD_W - `ICACHE_BYTE_W)

`endif

// ==== icache_addr_pkg.sv ====
// address field types for a physical, byte-addressed fetch port
// both address views overlay the same 32-bit word
`include "icache_consts.svh"

package icache_addr_pkg;

  typedef logic [`ICACHE_TAG_W-1:0]  tag_t;
  typedef logic [`ICACHE_IDX_W-1:0]  idx_t;
  typedef logic [`ICACHE_WORD_W-1:0] word_t;
  typedef logic [31:0]               instr_t;

  // normal fetch / hit-invalidate decoding
  typedef struct packed {
    tag_t                       tag;
    idx_t                       index;
    word_t                      word;
    logic [`ICACHE_BYTE_W-1:0]  byte_sel;
  } fetch_addr_t;

  // index-invalidate decoding, way sits in the lowest bits
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]                                  upper;
    idx_t                                                      index;
    logic [`ICACHE_WORD_W+`ICACHE_BYTE_W-`ICACHE_WAY_W-1:0]    spare;
    logic [`ICACHE_WAY_W-1:0]                                  way;
  } maint_addr_t;

  typedef union packed {
    fetch_addr_t fetch;
    maint_addr_t maint;
  } icache_addr_u;

endpackage

// ==== icache_op_pkg.sv ====
// request operation codes and refill FSM states
// encoding 2'b11 is not a valid operation

package icache_op_pkg;

  // request operation
  typedef enum logic [1:0] {
    OP_FETCH   = 2'd0,
    OP_IDX_INV = 2'd1,
    OP_HIT_INV = 2'd2
  } icache_op_e;

  // memory side burst
  typedef enum logic [1:0] {
    RF_IDLE = 2'd0,
    RF_ADDR = 2'd1,
    RF_DATA = 2'd2
  } refill_state_e;

endpackage

// ==== icache_if.sv ====
// internal bundles between the cache submodules
// no clocks here, every sequential element lives in a module
`timescale 1ns/1ps
`include "icache_consts.svh"

// stage-1 contents plus the advance strobe going back
interface stage_if import icache_addr_pkg::*, icache_op_pkg::*; ();
  logic         s1_valid;
  icache_op_e   s1_op;
  icache_addr_u s1_addr;
  logic         s1_adef;
  logic         s1_advance;

  modport source (output s1_valid, s1_op, s1_addr, s1_adef, input s1_advance);
  modport sink   (input s1_valid, s1_op, s1_addr, s1_adef, output s1_advance);
endinterface

// tag/valid/data/replacement arrays
interface array_if import icache_addr_pkg::*; ();
  idx_t                                           rd_idx;
  logic [`ICACHE_WAYS-1:0]                        tag_we;
  logic [`ICACHE_WAYS-1:0]                        valid_we;
  idx_t                                           wr_idx;
  tag_t                                           wr_tag;
  instr_t [`ICACHE_LINE_WORDS-1:0]                wr_line;
  logic                                           wr_valid;
  logic                                           repl_we;
  logic [`ICACHE_WAY_W-1:0]                       repl_wdata;
  tag_t [`ICACHE_WAYS-1:0]                        rd_tag;
  logic [`ICACHE_WAYS-1:0]                        rd_valid;
  instr_t [`ICACHE_WAYS-1:0][`ICACHE_LINE_WORDS-1:0] rd_line;
  logic [`ICACHE_WAY_W-1:0]                       rd_repl;

  modport read_idx (output rd_idx);
  modport control (
    output tag_we, valid_we, wr_idx, wr_tag, wr_line, wr_valid, repl_we, repl_wdata,
    input  rd_tag, rd_valid, rd_line, rd_repl
  );
  modport storage (
    input  rd_idx, tag_we, valid_we, wr_idx, wr_tag, wr_line, wr_valid, repl_we, repl_wdata,
    output rd_tag, rd_valid, rd_line, rd_repl
  );
endinterface

// line refill request and returned line
interface refill_if import icache_addr_pkg::*; ();
  logic                            refill_start;
  icache_addr_u                    line_addr;
  logic                            refill_done;
  instr_t [`ICACHE_LINE_WORDS-1:0] line;

  modport requester (output refill_start, line_addr, input refill_done, line);
  modport responder (input refill_start, line_addr, output refill_done, line);
endinterface

// ==== icache_req_stage.sv ====
// accepts one request per cycle into stage 1
// stage 1 holds until the lookup reports that it advances
// array read index follows the port only when stage 1 reloads
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_req_stage
  import icache_addr_pkg::*, icache_op_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_valid_i,
  input  icache_op_e   req_op_i,
  input  icache_addr_u req_addr_i,
  output logic         req_ready_o,
  stage_if.source      st,
  array_if.read_idx    arr
);

  logic s1_load;
  logic adef_in;

  // stage 1 empty or its response leaves this cycle
  assign s1_load     = !st.s1_valid || st.s1_advance;
  assign req_ready_o = s1_load;

  // only fetches care about word alignment
  assign adef_in = (req_op_i == OP_FETCH) && (req_addr_i.fetch.byte_sel != '0);

  // ====================
  // stage 1 register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st.s1_valid <= 1'b0;
    end else if (s1_load) begin
      st.s1_valid <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load && req_valid_i) begin
      st.s1_op   <= req_op_i;
      st.s1_addr <= req_addr_i;
      st.s1_adef <= adef_in;
    end
  end

  // read the incoming set, or keep re-reading the held one
  // so refill and invalidate writes show up while stalled
  assign arr.rd_idx = s1_load ? req_addr_i.fetch.index : st.s1_addr.fetch.index;

endmodule

// ==== icache_ways.sv ====
// per-way tag, valid and line arrays plus one replacement bit per set
// all reads are registered, one cycle after rd_idx
// a write to the set being read is forwarded into the read register
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ways
  import icache_addr_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  array_if.storage arr
);

  tag_t                            tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
  instr_t [`ICACHE_LINE_WORDS-1:0] line_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0]   valid_q;
  logic [`ICACHE_SETS-1:0][`ICACHE_WAY_W-1:0]  repl_q;
  logic                                        same_set;

  assign same_set = (arr.wr_idx == arr.rd_idx);

  // ====================
  // tags and lines
  // ====================
  always_ff @(posedge clk) begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (arr.tag_we[w]) begin
        tag_mem[w][arr.wr_idx]  <= arr.wr_tag;
        line_mem[w][arr.wr_idx] <= arr.wr_line;
      end
      arr.rd_tag[w]  <= (arr.tag_we[w] && same_set) ? arr.wr_tag : tag_mem[w][arr.rd_idx];
      arr.rd_line[w] <= (arr.tag_we[w] && same_set) ? arr.wr_line : line_mem[w][arr.rd_idx];
    end
  end

  // ====================
  // valid and replacement bits
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q      <= '0;
      repl_q       <= '0;
      arr.rd_valid <= '0;
      arr.rd_repl  <= '0;
    end else begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (arr.valid_we[w]) begin
          valid_q[w][arr.wr_idx] <= arr.wr_valid;
        end
        arr.rd_valid[w] <= (arr.valid_we[w] && same_set) ? arr.wr_valid
                                                         : valid_q[w][arr.rd_idx];
      end
      if (arr.repl_we) begin
        repl_q[arr.wr_idx] <= arr.repl_wdata;
      end
      arr.rd_repl <= (arr.repl_we && same_set) ? arr.repl_wdata : repl_q[arr.rd_idx];
    end
  end

endmodule

// ==== icache_lookup.sv ====
// stage-1 tag compare, response and array write control
// purely combinational, state lives in the request stage and the arrays
// victim and replacement update assume two ways (next way = ~used way)
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_lookup
  import icache_addr_pkg::*, icache_op_pkg::*;
(
  input  logic         rsp_ready_i,
  output logic         rsp_valid_o,
  output instr_t       rsp_instr_o,
  output logic         rsp_adef_o,
  stage_if.sink        st,
  array_if.control     arr,
  refill_if.requester  rf
);

  logic [`ICACHE_WAYS-1:0]  match;
  logic [`ICACHE_WAY_W-1:0] hit_way;
  logic [`ICACHE_WAY_W-1:0] victim;
  logic                     hit;
  logic                     is_fetch;
  logic                     fetch_ok;
  logic                     complete;

  // ====================
  // tag compare
  // ====================
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      match[w] = arr.rd_valid[w] && (arr.rd_tag[w] == st.s1_addr.fetch.tag);
      if (match[w]) begin
        hit_way = w[`ICACHE_WAY_W-1:0];
      end
    end
  end

  assign hit      = |match;
  assign victim   = arr.rd_repl;
  assign is_fetch = (st.s1_op == OP_FETCH);
  assign fetch_ok = is_fetch && !st.s1_adef;

  // maintenance finishes at once, fetch on hit or address error
  assign complete      = !is_fetch || st.s1_adef || hit;
  assign rsp_valid_o   = st.s1_valid && complete;
  assign rsp_adef_o    = is_fetch && st.s1_adef;
  assign rsp_instr_o   = (fetch_ok && hit) ? arr.rd_line[hit_way][st.s1_addr.fetch.word] : '0;
  assign st.s1_advance = rsp_valid_o && rsp_ready_i;

  // held high until the refilled line reads back as a hit
  assign rf.refill_start = st.s1_valid && fetch_ok && !hit;
  assign rf.line_addr    = st.s1_addr;

  // ====================
  // array writes
  // ====================
  assign arr.wr_idx  = st.s1_addr.fetch.index;
  assign arr.wr_tag  = st.s1_addr.fetch.tag;
  assign arr.wr_line = rf.line;

  always_comb begin
    arr.tag_we     = '0;
    arr.valid_we   = '0;
    arr.wr_valid   = 1'b0;
    arr.repl_we    = 1'b0;
    arr.repl_wdata = ~hit_way;
    if (st.s1_valid) begin
      case (st.s1_op)
        OP_FETCH: begin
          if (rf.refill_done) begin
            arr.tag_we[victim]   = 1'b1;
            arr.valid_we[victim] = 1'b1;
            arr.wr_valid         = 1'b1;
            arr.repl_we          = 1'b1;
            arr.repl_wdata       = ~victim;
          end else if (fetch_ok && hit) begin
            arr.repl_we = 1'b1;
          end
        end
        // way comes from the low address bits
        OP_IDX_INV: arr.valid_we[st.s1_addr.maint.way] = 1'b1;
        OP_HIT_INV: arr.valid_we = match;
        default: ;
      endcase
    end
  end

endmodule

// ==== icache_refill.sv ====
// line refill over a read-only AXI-style channel (AR and R)
// burst length is fixed at one line, beats arrive in word order
// refill_done pulses on the last beat with that beat forwarded directly
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_refill
  import icache_addr_pkg::*, icache_op_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         mem_ar_ready_i,
  input  logic         mem_r_valid_i,
  input  instr_t       mem_r_data_i,
  input  logic         mem_r_last_i,
  output logic         mem_ar_valid_o,
  output icache_addr_u mem_ar_addr_o,
  output logic         mem_r_ready_o,
  refill_if.responder  rf
);

  refill_state_e                   state_q;
  word_t                           cnt_q;
  instr_t [`ICACHE_LINE_WORDS-2:0] beat_buf;
  icache_addr_u                    line_base;
  logic                            beat;

  // clear word and byte fields to get the line address
  always_comb begin
    line_base                = rf.line_addr;
    line_base.fetch.word     = '0;
    line_base.fetch.byte_sel = '0;
  end

  assign beat = (state_q == RF_DATA) && mem_r_valid_i;

  // ====================
  // burst FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RF_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        RF_IDLE: begin
          cnt_q <= '0;
          if (rf.refill_start) state_q <= RF_ADDR;
        end
        RF_ADDR: if (mem_ar_ready_i) state_q <= RF_DATA;
        RF_DATA: begin
          if (beat) begin
            cnt_q <= cnt_q + 1'b1;
            if (mem_r_last_i) state_q <= RF_IDLE;
          end
        end
        default: state_q <= RF_IDLE;
      endcase
    end
  end

  // address latched at start, beats except the last go to the buffer
  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE && rf.refill_start) mem_ar_addr_o <= line_base;
    if (beat && !mem_r_last_i) beat_buf[cnt_q] <= mem_r_data_i;
  end

  assign mem_ar_valid_o = (state_q == RF_ADDR);
  assign mem_r_ready_o  = (state_q == RF_DATA);
  assign rf.refill_done = beat && mem_r_last_i;
  assign rf.line        = {mem_r_data_i, beat_buf};

endmodule

// ==== icache_top.sv ====
// two-way set-associative instruction cache, physical addresses only
// one request port shared by fetch and maintenance operations
// memory side is a read burst of one full line, no write channels
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top
  import icache_addr_pkg::*, icache_op_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  // request port
  input  logic         req_valid_i,
  input  icache_op_e   req_op_i,
  input  icache_addr_u req_addr_i,
  output logic         req_ready_o,
  // response port
  output logic         rsp_valid_o,
  output instr_t       rsp_instr_o,
  output logic         rsp_adef_o,
  input  logic         rsp_ready_i,
  // memory read channel
  output logic         mem_ar_valid_o,
  output icache_addr_u mem_ar_addr_o,
  input  logic         mem_ar_ready_i,
  input  logic         mem_r_valid_i,
  input  instr_t       mem_r_data_i,
  input  logic         mem_r_last_i,
  output logic         mem_r_ready_o
);

  stage_if  u_stage ();
  array_if  u_array ();
  refill_if u_refill ();

  icache_req_stage i_req_stage (
    .clk, .rst_n, .req_valid_i, .req_op_i, .req_addr_i, .req_ready_o,
    .st  (u_stage),
    .arr (u_array)
  );

  icache_ways i_ways (.clk, .rst_n, .arr (u_array));

  icache_lookup i_lookup (
    .rsp_ready_i, .rsp_valid_o, .rsp_instr_o, .rsp_adef_o,
    .st  (u_stage),
    .arr (u_array),
    .rf  (u_refill)
  );

  icache_refill i_refill (
    .clk, .rst_n, .mem_ar_ready_i, .mem_r_valid_i, .mem_r_data_i, .mem_r_last_i,
    .mem_ar_valid_o, .mem_ar_addr_o, .mem_r_ready_o,
    .rf (u_refill)
  );

endmodule

// ==== icache_assert.sv ====
// handshake rules of the cache ports, bound to icache_top
// hold rules are checked only outside reset
`timescale 1ns/1ps

module icache_assert (
  input logic clk,
  input logic rst_n,
  input logic ar_valid_i,
  input logic ar_ready_i,
  input logic r_ready_i,
  input logic rsp_valid_i,
  input logic rsp_ready_i
);

  // address request stays up until the memory takes it
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i)
    else $error("mem_ar_valid_o dropped before the address handshake");

  // response stays up until the requester takes it
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i)
    else $error("rsp_valid_o dropped before the response handshake");

  // address and data phase never overlap
  ar_in_data: assert property (@(posedge clk) disable iff (!rst_n)
    !(ar_valid_i && r_ready_i))
    else $error("mem_ar_valid_o raised during a data phase");

  rsp_in_reset: assert property (@(posedge clk) !rst_n |-> !rsp_valid_i)
    else $error("rsp_valid_o high while reset is asserted");

endmodule

bind icache_top icache_assert i_icache_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .ar_valid_i  (mem_ar_valid_o),
  .ar_ready_i  (mem_ar_ready_i),
  .r_ready_i   (mem_r_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i)
);

// ==== tb_icache.sv ====
// random fetch and maintenance traffic checked against a model of tags,
// valid bits and replacement bits; memory word = address XOR a constant
// the cache holds at most one request, so one expected response is kept
`timescale 1ns/1ps
`include "icache_consts.svh"

module tb_icache
  import icache_addr_pkg::*, icache_op_pkg::*;
();

  localparam int     n_req          = 2000;
  localparam int     timeout_cycles = 40 * n_req;
  localparam instr_t mem_xor        = 32'h5a5a_c3c3;

  logic         clk;
  logic         rst_n;
  logic         req_valid_i;
  icache_op_e   req_op_i;
  icache_addr_u req_addr_i;
  logic         req_ready_o;
  logic         rsp_valid_o;
  instr_t       rsp_instr_o;
  logic         rsp_adef_o;
  logic         rsp_ready_i;
  logic         mem_ar_valid_o;
  icache_addr_u mem_ar_addr_o;
  logic         mem_ar_ready_i;
  logic         mem_r_valid_i;
  instr_t       mem_r_data_i;
  logic         mem_r_last_i;
  logic         mem_r_ready_o;

  // reference model
  tag_t m_tag   [`ICACHE_WAYS][`ICACHE_SETS];
  logic m_valid [`ICACHE_WAYS][`ICACHE_SETS];
  logic m_repl  [`ICACHE_SETS];

  // expected response of the request in stage 1
  logic         pend_valid;
  logic         pend_fresh;
  logic         pend_miss;
  logic         pend_adef;
  logic         pend_ar_seen;
  instr_t       pend_instr;
  icache_addr_u pend_line;
  string        pend_name;

  // memory responder
  logic         mem_busy;
  icache_addr_u mem_base;
  word_t        mem_beat;

  icache_op_e   dir_op   [$];
  icache_addr_u dir_addr [$];
  logic         req_taken;
  logic         r_taken;
  int           n_sent;
  int           n_done;
  int           cycle_cnt;
  int unsigned  seed_ret;

  icache_top i_icache_top (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================
  // helpers
  // ====================
  function automatic instr_t mem_word(input icache_addr_u a);
    return a ^ mem_xor;
  endfunction

  function automatic icache_addr_u mk_addr(input tag_t t, input idx_t i, input word_t w,
                                           input logic [1:0] b);
    icache_addr_u a;
    a.fetch.tag      = t;
    a.fetch.index    = i;
    a.fetch.word     = w;
    a.fetch.byte_sel = b;
    return a;
  endfunction

  task automatic add_dir(input icache_op_e op, input tag_t t, input idx_t i, input word_t w,
                         input logic [1:0] b);
    dir_op.push_back(op);
    dir_addr.push_back(mk_addr(t, i, w, b));
  endtask

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(input string name, input icache_addr_u exp,
                            input icache_addr_u act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  // ====================
  // model update at acceptance
  // ====================
  task automatic predict(input icache_op_e op, input icache_addr_u a);
    idx_t s;
    tag_t t;
    logic hit;
    logic way;
    int   w;
    s   = a.fetch.index;
    t   = a.fetch.tag;
    hit = 1'b0;
    way = 1'b0;
    for (w = 0; w < `ICACHE_WAYS; w++) begin
      if (m_valid[w][s] && m_tag[w][s] == t) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    pend_valid   = 1'b1;
    pend_fresh   = 1'b1;
    pend_ar_seen = 1'b0;
    pend_miss    = 1'b0;
    pend_adef    = 1'b0;
    pend_instr   = '0;
    pend_line    = a;
    pend_line.fetch.word     = '0;
    pend_line.fetch.byte_sel = '0;
    case (op)
      OP_FETCH: begin
        if (a.fetch.byte_sel != '0) begin
          pend_adef = 1'b1;
        end else begin
          pend_instr = mem_word(a);
          if (hit) begin
            m_repl[s] = ~way;
          end else begin
            // victim is the way the set's bit points to
            pend_miss      = 1'b1;
            way            = m_repl[s];
            m_tag[way][s]  = t;
            m_valid[way][s] = 1'b1;
            m_repl[s]      = ~way;
          end
        end
      end
      OP_IDX_INV: m_valid[a.maint.way][s] = 1'b0;
      OP_HIT_INV: if (hit) m_valid[way][s] = 1'b0;
      default: ;
    endcase
  endtask

  // ====================
  // stimulus
  // ====================
  task automatic next_request();
    int unsigned r;
    icache_op_e  op;
    logic [1:0]  b;
    if (dir_op.size() > 0) begin
      req_op_i   = dir_op.pop_front();
      req_addr_i = dir_addr.pop_front();
    end else begin
      r  = $urandom % 100;
      op = (r < 5) ? OP_IDX_INV : (r < 10) ? OP_HIT_INV : OP_FETCH;
      b  = 2'd0;
      if (op == OP_IDX_INV) begin
        b = 2'($urandom % 2);
      end else if (op == OP_FETCH && ($urandom % 10) == 0) begin
        b = 2'(1 + $urandom % 3);
      end
      // few tags over few sets so lines collide and get evicted
      req_op_i   = op;
      req_addr_i = mk_addr(tag_t'(24'h000100 + $urandom % 3), idx_t'($urandom % 4),
                           word_t'($urandom % 4), b);
    end
  endtask

  task automatic drive_memory();
    icache_addr_u a;
    // an offered beat stays until it is taken
    if (!(mem_r_valid_i && !r_taken)) begin
      if (mem_busy) begin
        a            = mem_base;
        a.fetch.word = mem_beat;
        mem_r_valid_i = ($urandom % 4) != 0;
        mem_r_data_i  = mem_word(a);
        mem_r_last_i  = (mem_beat == 2'd3);
      end else begin
        mem_r_valid_i = 1'b0;
        mem_r_last_i  = 1'b0;
      end
    end
  endtask

  task automatic drive_cycle();
    rsp_ready_i    = ($urandom % 10) < 7;
    mem_ar_ready_i = ($urandom % 10) < 6;
    drive_memory();
    if (!req_valid_i || req_taken) begin
      if (n_sent < n_req && ($urandom % 5) != 0) begin
        req_valid_i = 1'b1;
        next_request();
      end else begin
        req_valid_i = 1'b0;
      end
    end
  endtask

  // ====================
  // sampling, mid-cycle
  // ====================
  task automatic sample_cycle();
    req_taken = 1'b0;
    r_taken   = 1'b0;
    cycle_cnt++;
    if (cycle_cnt > timeout_cycles) begin
      $display("timeout: only %0d of %0d responses after %0d cycles", n_done, n_req,
               cycle_cnt);
      stop_with_failure();
    end
    // hits and maintenance answer in the first cycle, misses do not
    if (pend_valid && pend_fresh) begin
      check_flag({pend_name, " one-cycle response"}, !pend_miss, rsp_valid_o);
      pend_fresh = 1'b0;
    end
    if (mem_ar_valid_o && mem_ar_ready_i) begin
      if (!pend_valid || pend_ar_seen) begin
        $display("memory address handshake with no fetch waiting for it");
        stop_with_failure();
      end
      check_flag({pend_name, " miss"}, pend_miss, 1'b1);
      check_addr({pend_name, " line address"}, pend_line, mem_ar_addr_o);
      pend_ar_seen = 1'b1;
      mem_busy     = 1'b1;
      mem_base     = mem_ar_addr_o;
      mem_beat     = '0;
    end
    if (mem_r_valid_i && mem_r_ready_o) begin
      r_taken  = 1'b1;
      mem_beat = mem_beat + 1'b1;
      if (mem_r_last_i) mem_busy = 1'b0;
    end
    if (rsp_valid_o && rsp_ready_i) begin
      if (!pend_valid) begin
        $display("response handed out with no request outstanding");
        stop_with_failure();
      end
      check_flag({pend_name, " adef"}, pend_adef, rsp_adef_o);
      if (!pend_adef) check_instr({pend_name, " instr"}, pend_instr, rsp_instr_o);
      check_flag({pend_name, " miss"}, pend_miss, pend_ar_seen);
      pend_valid = 1'b0;
      n_done++;
    end
    // stage 1 is free when empty or when its response leaves this cycle
    check_flag($sformatf("cycle%0d req_ready", cycle_cnt), !pend_valid, req_ready_o);
    if (req_valid_i && req_ready_o) begin
      predict(req_op_i, req_addr_i);
      pend_name = $sformatf("req%0d", n_sent);
      req_taken = 1'b1;
      n_sent++;
    end
  endtask

  initial begin
    seed_ret       = $urandom(33);
    rst_n          = 1'b0;
    req_valid_i    = 1'b0;
    req_op_i       = OP_FETCH;
    req_addr_i     = '0;
    rsp_ready_i    = 1'b0;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    mem_r_last_i   = 1'b0;
    pend_valid     = 1'b0;
    pend_fresh     = 1'b0;
    pend_ar_seen   = 1'b0;
    mem_busy       = 1'b0;
    mem_beat       = '0;
    n_sent         = 0;
    n_done         = 0;
    cycle_cnt      = 0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      m_repl[s] = 1'b0;
      for (int w = 0; w < `ICACHE_WAYS; w++) m_valid[w][s] = 1'b0;
    end
    // eviction order in set 5, then both invalidates
    add_dir(OP_FETCH,   24'h0000a0, 4'd5, 2'd0, 2'd0);
    add_dir(OP_FETCH,   24'h0000b0, 4'd5, 2'd0, 2'd0);
    add_dir(OP_FETCH,   24'h0000a0, 4'd5, 2'd1, 2'd0);
    add_dir(OP_FETCH,   24'h0000c0, 4'd5, 2'd0, 2'd0);
    add_dir(OP_FETCH,   24'h0000b0, 4'd5, 2'd2, 2'd0);
    add_dir(OP_FETCH,   24'h0000c0, 4'd5, 2'd1, 2'd0);
    add_dir(OP_HIT_INV, 24'h0000b0, 4'd5, 2'd0, 2'd0);
    add_dir(OP_FETCH,   24'h0000c0, 4'd5, 2'd2, 2'd0);
    add_dir(OP_FETCH,   24'h0000b0, 4'd5, 2'd3, 2'd0);
    add_dir(OP_IDX_INV, 24'h000000, 4'd5, 2'd0, 2'd1);
    add_dir(OP_FETCH,   24'h0000b0, 4'd5, 2'd0, 2'd0);
    add_dir(OP_FETCH,   24'h0000c0, 4'd5, 2'd3, 2'd0);
    add_dir(OP_FETCH,   24'h0000a0, 4'd5, 2'd0, 2'd2);
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    while (n_done < n_req) begin
      @(negedge clk);
      sample_cycle();
      @(posedge clk);
      #2;
      drive_cycle();
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
icache_addr_pkg.sv
icache_op_pkg.sv
icache_if.sv
icache_req_stage.sv
icache_ways.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
icache_assert.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_icache -f compile.f -o tb_icache_sim

sim_out=$(./obj_dir/tb_icache_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
